// File: design/ax_issue.sv
/*
 * Request issue FSM for one address channel (AW or AR)
 * - Chooses the reused or the lowest free output ID from the table flags
 * - Forwards the request and pushes it into the table in the same cycle
 * - Holds valid and output ID while the master port applies back-pressure
 */
`timescale 1ns/1ns

module ax_issue #(
  parameter int unsigned TableSize = remap_cfg_pkg::DefaultTableSize
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     slv_valid_i,
  input  remap_types_pkg::slv_id_t slv_id_i,
  output logic                     slv_ready_o,
  output logic                     mst_valid_o,
  output remap_types_pkg::mst_id_t mst_id_o,
  input  logic                     mst_ready_i,
  remap_table_if.issue             tbl
);
  import remap_types_pkg::*;

  localparam int unsigned IdxWidth = $clog2(TableSize) > 0 ? $clog2(TableSize) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  issue_state_e state_d, state_q;
  idx_t         held_id_d, held_id_q;
  idx_t         oup_id;
  logic         slot_ok;

  // The table is searched with the ID of the request waiting on the slave port
  assign tbl.lookup_id   = slv_id_i;
  assign tbl.push_inp_id = slv_id_i;

  // A known input ID needs room in its entry, a new one needs any free entry
  assign slot_ok = tbl.exists ? !tbl.exists_full : !tbl.full;

  always_comb begin
    state_d     = state_q;
    held_id_d   = held_id_q;
    oup_id      = held_id_q;
    mst_valid_o = 1'b0;
    slv_ready_o = 1'b0;
    tbl.push    = 1'b0;

    unique case (state_q)
      IssueReady: begin
        // Reusing the output ID of an in-flight burst keeps responses in order
        oup_id = tbl.exists ? tbl.exists_oup_id : tbl.free_oup_id;
        if (slv_valid_i && slot_ok) begin
          mst_valid_o = 1'b1;
          slv_ready_o = mst_ready_i;
          tbl.push    = 1'b1;
          if (!mst_ready_i) begin
            held_id_d = oup_id;
            state_d   = IssueHold;
          end
        end
      end
      IssueHold: begin
        // The burst is already in the table, only the handshake is pending
        mst_valid_o = 1'b1;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = IssueReady;
        end
      end
      default: state_d = IssueReady;
    endcase
  end

  assign tbl.push_oup_id = oup_id;
  assign mst_id_o        = mst_id_t'(oup_id);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IssueReady;
      held_id_q <= '0;
    end else begin
      state_q   <= state_d;
      held_id_q <= held_id_d;
    end
  end

  // A request offered to the master stays there unchanged until accepted
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_valid_o && !mst_ready_i |=> mst_valid_o && $stable(mst_id_o));

endmodule

// File: design/axi_id_remap_top.sv
/*
 * AXI ID remapper from a wide-ID slave port to a narrow-ID master port
 * - Separate write and read remap tables
 * - One issue FSM per address channel
 * - Shared restore logic for B and R responses
 * - Address, length, data, response and last pass through unchanged
 */
`timescale 1ns/1ns

module axi_id_remap_top #(
  parameter int unsigned TableSize = remap_cfg_pkg::DefaultTableSize,
  parameter int unsigned MaxTxns   = remap_cfg_pkg::DefaultMaxTxns
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // AW channel
  input  logic                     slv_aw_valid_i,
  input  remap_types_pkg::slv_id_t slv_aw_id_i,
  input  remap_types_pkg::addr_t   slv_aw_addr_i,
  input  remap_types_pkg::len_t    slv_aw_len_i,
  output logic                     slv_aw_ready_o,
  output logic                     mst_aw_valid_o,
  output remap_types_pkg::mst_id_t mst_aw_id_o,
  output remap_types_pkg::addr_t   mst_aw_addr_o,
  output remap_types_pkg::len_t    mst_aw_len_o,
  input  logic                     mst_aw_ready_i,
  // AR channel
  input  logic                     slv_ar_valid_i,
  input  remap_types_pkg::slv_id_t slv_ar_id_i,
  input  remap_types_pkg::addr_t   slv_ar_addr_i,
  input  remap_types_pkg::len_t    slv_ar_len_i,
  output logic                     slv_ar_ready_o,
  output logic                     mst_ar_valid_o,
  output remap_types_pkg::mst_id_t mst_ar_id_o,
  output remap_types_pkg::addr_t   mst_ar_addr_o,
  output remap_types_pkg::len_t    mst_ar_len_o,
  input  logic                     mst_ar_ready_i,
  // B channel
  input  logic                     mst_b_valid_i,
  input  remap_types_pkg::mst_id_t mst_b_id_i,
  input  remap_types_pkg::resp_t   mst_b_resp_i,
  output logic                     mst_b_ready_o,
  output logic                     slv_b_valid_o,
  output remap_types_pkg::slv_id_t slv_b_id_o,
  output remap_types_pkg::resp_t   slv_b_resp_o,
  input  logic                     slv_b_ready_i,
  // R channel
  input  logic                     mst_r_valid_i,
  input  remap_types_pkg::mst_id_t mst_r_id_i,
  input  remap_types_pkg::data_t   mst_r_data_i,
  input  remap_types_pkg::resp_t   mst_r_resp_i,
  input  logic                     mst_r_last_i,
  output logic                     mst_r_ready_o,
  output logic                     slv_r_valid_o,
  output remap_types_pkg::slv_id_t slv_r_id_o,
  output remap_types_pkg::data_t   slv_r_data_o,
  output remap_types_pkg::resp_t   slv_r_resp_o,
  output logic                     slv_r_last_o,
  input  logic                     slv_r_ready_i
);

  remap_table_if #(.TableSize(TableSize)) wr_tbl ();
  remap_table_if #(.TableSize(TableSize)) rd_tbl ();

  // Payload is never touched, only IDs and address handshakes are
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;

  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;

  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

  ax_issue #(.TableSize(TableSize)) u_wr_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .slv_valid_i (slv_aw_valid_i),
    .slv_id_i    (slv_aw_id_i),
    .slv_ready_o (slv_aw_ready_o),
    .mst_valid_o (mst_aw_valid_o),
    .mst_id_o    (mst_aw_id_o),
    .mst_ready_i (mst_aw_ready_i),
    .tbl         (wr_tbl.issue)
  );

  ax_issue #(.TableSize(TableSize)) u_rd_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .slv_valid_i (slv_ar_valid_i),
    .slv_id_i    (slv_ar_id_i),
    .slv_ready_o (slv_ar_ready_o),
    .mst_valid_o (mst_ar_valid_o),
    .mst_id_o    (mst_ar_id_o),
    .mst_ready_i (mst_ar_ready_i),
    .tbl         (rd_tbl.issue)
  );

  id_remap_table #(.TableSize(TableSize), .MaxTxns(MaxTxns)) u_wr_table (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tbl    (wr_tbl.table_side)
  );

  id_remap_table #(.TableSize(TableSize), .MaxTxns(MaxTxns)) u_rd_table (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tbl    (rd_tbl.table_side)
  );

  resp_id_restore u_restore (
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_id_i    (mst_b_id_i),
    .slv_b_ready_i (slv_b_ready_i),
    .slv_b_id_o    (slv_b_id_o),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_last_i  (mst_r_last_i),
    .slv_r_ready_i (slv_r_ready_i),
    .slv_r_id_o    (slv_r_id_o),
    .wr            (wr_tbl.restore),
    .rd            (rd_tbl.restore)
  );

endmodule

// File: design/id_remap_table.sv
/*
 * Remap table indexed by output ID
 * - Each entry holds an input ID and a count of bursts in flight
 * - Priority search for the lowest free output ID
 * - Match of the lookup ID against busy entries
 * - Counter update on push and pop, both possible in one cycle
 */
`timescale 1ns/1ns

module id_remap_table #(
  parameter int unsigned TableSize = remap_cfg_pkg::DefaultTableSize,
  parameter int unsigned MaxTxns   = remap_cfg_pkg::DefaultMaxTxns
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  remap_table_if.table_side tbl
);
  import remap_types_pkg::*;

  localparam int unsigned IdxWidth = $clog2(TableSize) > 0 ? $clog2(TableSize) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);
  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [CntWidth-1:0] cnt_t;

  slv_id_t              inp_id_q [TableSize];
  cnt_t                 cnt_q    [TableSize];
  logic [TableSize-1:0] busy;
  logic [TableSize-1:0] match;
  logic [TableSize-1:0] push_hit;
  logic [TableSize-1:0] pop_hit;
  idx_t                 pop_idx;
  idx_t                 free_id;
  idx_t                 match_id;

  // Master IDs are at least as wide as the index, the upper bits stay zero
  assign pop_idx = idx_t'(tbl.pop_oup_id);

  for (genvar i = 0; i < TableSize; i++) begin : gen_entry
    assign busy[i]     = cnt_q[i] != '0;
    assign match[i]    = busy[i] && (inp_id_q[i] == tbl.lookup_id);
    assign push_hit[i] = tbl.push && (tbl.push_oup_id == idx_t'(i));
    assign pop_hit[i]  = tbl.pop && (pop_idx == idx_t'(i));
  end

  // Walking down from the top leaves the lowest hit in place
  always_comb begin
    free_id  = '0;
    match_id = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_id = idx_t'(i);
      end
      if (match[i]) begin
        match_id = idx_t'(i);
      end
    end
  end

  assign tbl.free_oup_id   = free_id;
  assign tbl.full          = &busy;
  assign tbl.exists        = |match;
  assign tbl.exists_oup_id = match_id;
  assign tbl.exists_full   = cnt_q[match_id] == cnt_t'(MaxTxns);
  assign tbl.pop_inp_id    = inp_id_q[pop_idx];

  // Input IDs only mean something while the counter of their entry is nonzero
  always_ff @(posedge clk_i) begin
    if (tbl.push) begin
      inp_id_q[tbl.push_oup_id] <= tbl.push_inp_id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < TableSize; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < TableSize; i++) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(push_hit[i]) - cnt_t'(pop_hit[i]);
      end
    end
  end

  // A push either opens a free entry or joins the entry of its own input ID
  a_push_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl.push |-> !busy[tbl.push_oup_id] ||
                 (inp_id_q[tbl.push_oup_id] == tbl.push_inp_id));

  a_push_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl.push |-> cnt_q[tbl.push_oup_id] < cnt_t'(MaxTxns));

  // Every response popped by the restore logic belongs to a burst in flight
  a_pop_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl.pop |-> busy[pop_idx]);

  a_match_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(match));

endmodule

// File: design/remap_cfg_pkg.sv
/*
 * Configuration constants of the AXI ID remapper
 * - Default table size and burst limit per table entry
 * - ID widths of the slave and master ports
 * - Address and data widths shared by both ports
 */
package remap_cfg_pkg;

  // Number of output IDs per table, so the master port needs two ID bits
  localparam int unsigned DefaultTableSize = 4;

  // Bursts that may share one output ID at a time
  localparam int unsigned DefaultMaxTxns = 3;

  // Slave side carries the wide IDs, master side only the table index
  localparam int unsigned SlvIdWidth = 6;
  localparam int unsigned MstIdWidth = 2;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

endpackage

// File: design/remap_table_if.sv
/*
 * Connection bundle of one remap table
 * - Push and lookup signals used by the request issue FSM
 * - Pop signals used by the response ID restore logic
 * - Modports for the issue side, the table itself and the restore side
 */
`timescale 1ns/1ns

interface remap_table_if #(
  parameter int unsigned TableSize = remap_cfg_pkg::DefaultTableSize
);
  import remap_types_pkg::*;

  localparam int unsigned IdxWidth = $clog2(TableSize) > 0 ? $clog2(TableSize) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  // New burst entering the table
  logic    push;
  slv_id_t push_inp_id;
  idx_t    push_oup_id;

  // Search for the input ID of the pending request
  slv_id_t lookup_id;
  logic    exists;
  idx_t    exists_oup_id;
  logic    exists_full;
  logic    full;
  idx_t    free_oup_id;

  // Pop carries the raw master-side ID of the response
  logic    pop;
  mst_id_t pop_oup_id;
  slv_id_t pop_inp_id;

  modport issue (
    output push, push_inp_id, push_oup_id, lookup_id,
    input  exists, exists_oup_id, exists_full, full, free_oup_id
  );

  modport table_side (
    input  push, push_inp_id, push_oup_id, lookup_id, pop, pop_oup_id,
    output exists, exists_oup_id, exists_full, full, free_oup_id, pop_inp_id
  );

  modport restore (
    output pop, pop_oup_id,
    input  pop_inp_id
  );

endinterface

// File: design/remap_types_pkg.sv
/*
 * Types of the AXI ID remapper
 * - ID types of both ports
 * - Address, data, response and burst length payload types
 * - State encoding of the request issue FSM
 */
package remap_types_pkg;

  // IDs on the two sides of the remapper
  typedef logic [remap_cfg_pkg::SlvIdWidth-1:0] slv_id_t;
  typedef logic [remap_cfg_pkg::MstIdWidth-1:0] mst_id_t;

  // Payload fields that pass the remapper unchanged
  typedef logic [remap_cfg_pkg::AddrWidth-1:0] addr_t;
  typedef logic [remap_cfg_pkg::DataWidth-1:0] data_t;
  typedef logic [1:0]                          resp_t;
  typedef logic [7:0]                          len_t;

  // IssueHold keeps an accepted request on the master port until it is taken
  typedef enum logic {
    IssueReady = 1'b0,
    IssueHold  = 1'b1
  } issue_state_e;

endpackage

// File: design/resp_id_restore.sv
/*
 * Response ID restore for the B and R channels
 * - Looks up the original input ID by the returned output ID
 * - Pops a write burst on every B handshake
 * - Pops a read burst only on the R handshake that carries last
 */
`timescale 1ns/1ns

module resp_id_restore (
  input  logic                     mst_b_valid_i,
  input  remap_types_pkg::mst_id_t mst_b_id_i,
  input  logic                     slv_b_ready_i,
  output remap_types_pkg::slv_id_t slv_b_id_o,
  input  logic                     mst_r_valid_i,
  input  remap_types_pkg::mst_id_t mst_r_id_i,
  input  logic                     mst_r_last_i,
  input  logic                     slv_r_ready_i,
  output remap_types_pkg::slv_id_t slv_r_id_o,
  remap_table_if.restore           wr,
  remap_table_if.restore           rd
);

  // The table lookup is combinational, so the ID follows the response directly
  assign wr.pop_oup_id = mst_b_id_i;
  assign slv_b_id_o    = wr.pop_inp_id;
  assign rd.pop_oup_id = mst_r_id_i;
  assign slv_r_id_o    = rd.pop_inp_id;

  // Ready travels straight from the slave port, so this is the real handshake
  assign wr.pop = mst_b_valid_i && slv_b_ready_i;

  // Beats before last leave the read entry busy
  assign rd.pop = mst_r_valid_i && slv_r_ready_i && mst_r_last_i;

  // A response may only name an output ID whose entry has been written
  a_wr_id_known: assert final (!mst_b_valid_i || !$isunknown(slv_b_id_o));

  a_rd_id_known: assert final (!mst_r_valid_i || !$isunknown(slv_r_id_o));

endmodule

// File: verification/tb_axi_id_remap.sv
/*
 * Testbench of the AXI ID remapper
 * - Clock, reset and stimulus for the AW, AR, B and R channels
 * - Reference model of the write and read remap tables
 * - Compare tasks, a channel monitor and a cycle limit
 */
`timescale 1ns/1ns

module tb_axi_id_remap;
  import remap_types_pkg::*;

  localparam int unsigned TableSize  = 4;
  localparam int unsigned MaxTxns    = 3;
  localparam int unsigned CycleLimit = 2000;

  logic    clk_i;
  logic    rst_ni;
  logic    slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
  slv_id_t slv_aw_id_i;
  mst_id_t mst_aw_id_o;
  addr_t   slv_aw_addr_i, mst_aw_addr_o;
  len_t    slv_aw_len_i, mst_aw_len_o;
  logic    slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  slv_id_t slv_ar_id_i;
  mst_id_t mst_ar_id_o;
  addr_t   slv_ar_addr_i, mst_ar_addr_o;
  len_t    slv_ar_len_i, mst_ar_len_o;
  logic    mst_b_valid_i, mst_b_ready_o, slv_b_valid_o, slv_b_ready_i;
  mst_id_t mst_b_id_i;
  slv_id_t slv_b_id_o;
  resp_t   mst_b_resp_i, slv_b_resp_o;
  logic    mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  logic    slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  mst_id_t mst_r_id_i;
  slv_id_t slv_r_id_o;
  data_t   mst_r_data_i, slv_r_data_o;
  resp_t   mst_r_resp_i, slv_r_resp_o;

  // Model of both tables, index 0 is the write table and index 1 the read table
  int      mdl_cnt [2][TableSize];
  slv_id_t mdl_inp [2][TableSize];
  int      cycles;

  axi_id_remap_top #(.TableSize(TableSize), .MaxTxns(MaxTxns)) axi_id_remap_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_mst_id(input string name, input mst_id_t got, input mst_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_slv_id(input string name, input slv_id_t got, input slv_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_payload(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_stall(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Returns the output ID a request gets, or -1 when it has to wait
  function automatic int ref_oup_id(input logic is_rd, input slv_id_t id);
    // An in-flight input ID is bound to its entry even when that entry is full
    for (int i = 0; i < TableSize; i++) begin
      if (mdl_cnt[is_rd][i] != 0 && mdl_inp[is_rd][i] == id) begin
        return (mdl_cnt[is_rd][i] >= MaxTxns) ? -1 : i;
      end
    end
    for (int i = 0; i < TableSize; i++) begin
      if (mdl_cnt[is_rd][i] == 0) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic drive_addr(input logic is_rd, input logic valid, input slv_id_t id,
                            input addr_t addr, input logic rdy);
    if (is_rd) begin
      slv_ar_valid_i <= valid;
      slv_ar_id_i    <= id;
      slv_ar_addr_i  <= addr;
      slv_ar_len_i   <= addr[31:24];
      mst_ar_ready_i <= rdy;
    end else begin
      slv_aw_valid_i <= valid;
      slv_aw_id_i    <= id;
      slv_aw_addr_i  <= addr;
      slv_aw_len_i   <= addr[31:24];
      mst_aw_ready_i <= rdy;
    end
  endtask

  // Offers one request and keeps master ready low for gap cycles
  task automatic send_addr(input logic is_rd, input slv_id_t id, input addr_t addr,
                           input int gap);
    int    exp;
    int    k;
    logic  done;
    string ch;
    ch  = is_rd ? "ar" : "aw";
    exp = ref_oup_id(is_rd, id);
    if (exp < 0) begin
      stop_on_error("A request that should issue found no slot in the reference model");
    end
    mdl_cnt[is_rd][exp]++;
    mdl_inp[is_rd][exp] = id;
    drive_addr(is_rd, 1'b1, id, addr, gap == 0);
    k    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      check_stall({"mst_", ch, "_valid_o"}, is_rd ? mst_ar_valid_o : mst_aw_valid_o, 1'b1);
      check_mst_id({"mst_", ch, "_id_o"}, is_rd ? mst_ar_id_o : mst_aw_id_o, mst_id_t'(exp));
      check_payload({"mst_", ch, "_addr_o"}, is_rd ? mst_ar_addr_o : mst_aw_addr_o, addr);
      check_payload({"mst_", ch, "_len_o"}, addr_t'(is_rd ? mst_ar_len_o : mst_aw_len_o),
                    addr_t'(addr[31:24]));
      done = is_rd ? slv_ar_ready_o : slv_aw_ready_o;
      @(posedge clk_i);
      k++;
      drive_addr(is_rd, 1'b1, id, addr, k >= gap);
    end
    drive_addr(is_rd, 1'b0, id, addr, 1'b0);
  endtask

  // Leaves the request pending on the slave port after the stall cycles
  task automatic stall_addr(input logic is_rd, input slv_id_t id, input addr_t addr,
                            input int n);
    if (ref_oup_id(is_rd, id) >= 0) begin
      stop_on_error("A stall was expected but the reference model has a free slot");
    end
    drive_addr(is_rd, 1'b1, id, addr, 1'b1);
    repeat (n) begin
      @(negedge clk_i);
      check_stall(is_rd ? "mst_ar_valid_o" : "mst_aw_valid_o",
                  is_rd ? mst_ar_valid_o : mst_aw_valid_o, 1'b0);
      check_stall(is_rd ? "slv_ar_ready_o" : "slv_aw_ready_o",
                  is_rd ? slv_ar_ready_o : slv_aw_ready_o, 1'b0);
      @(posedge clk_i);
    end
  endtask

  task automatic send_resp(input logic is_rd, input int oup, input logic last);
    slv_id_t exp_id;
    data_t   data;
    resp_t   resp;
    if (mdl_cnt[is_rd][oup] == 0) begin
      stop_on_error("A response was sent for an output ID with no burst in flight");
    end
    exp_id = mdl_inp[is_rd][oup];
    data   = $urandom;
    resp   = resp_t'($urandom);
    if (is_rd) begin
      mst_r_valid_i <= 1'b1;
      mst_r_id_i    <= mst_id_t'(oup);
      mst_r_data_i  <= data;
      mst_r_resp_i  <= resp;
      mst_r_last_i  <= last;
      slv_r_ready_i <= 1'b1;
    end else begin
      mst_b_valid_i <= 1'b1;
      mst_b_id_i    <= mst_id_t'(oup);
      mst_b_resp_i  <= resp;
      slv_b_ready_i <= 1'b1;
    end
    @(negedge clk_i);
    if (is_rd) begin
      check_slv_id("slv_r_id_o", slv_r_id_o, exp_id);
      check_payload("slv_r_data_o", addr_t'(slv_r_data_o), addr_t'(data));
      check_payload("slv_r_resp_o", addr_t'(slv_r_resp_o), addr_t'(resp));
      check_stall("slv_r_last_o", slv_r_last_o, last);
    end else begin
      check_slv_id("slv_b_id_o", slv_b_id_o, exp_id);
      check_payload("slv_b_resp_o", addr_t'(slv_b_resp_o), addr_t'(resp));
    end
    if (!is_rd || last) begin
      mdl_cnt[is_rd][oup]--;
    end
    @(posedge clk_i);
    mst_r_valid_i <= 1'b0;
    mst_b_valid_i <= 1'b0;
    slv_r_ready_i <= 1'b0;
    slv_b_ready_i <= 1'b0;
  endtask

  // Handshake rules that hold in every cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (slv_aw_ready_o && !mst_aw_ready_i) begin
        stop_on_error("slv_aw_ready_o was high while mst_aw_ready_i was low");
      end
      if (slv_ar_ready_o && !mst_ar_ready_i) begin
        stop_on_error("slv_ar_ready_o was high while mst_ar_ready_i was low");
      end
      if (!slv_aw_valid_i) begin
        check_stall("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
      end
      if (!slv_ar_valid_i) begin
        check_stall("mst_ar_valid_o", mst_ar_valid_o, 1'b0);
      end
      check_stall("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i);
      check_stall("mst_r_ready_o", mst_r_ready_o, slv_r_ready_i);
      check_stall("slv_b_valid_o", slv_b_valid_o, mst_b_valid_i);
      check_stall("slv_r_valid_o", slv_r_valid_o, mst_r_valid_i);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      stop_on_error("The run passed its cycle limit before the tests finished");
    end
  end

  initial begin
    slv_id_t ids [5];
    slv_id_t base;
    addr_t   addr;
    void'($urandom(69145));
    cycles         = 0;
    rst_ni         = 1'b0;
    drive_addr(1'b0, 1'b0, '0, '0, 1'b0);
    drive_addr(1'b1, 1'b0, '0, '0, 1'b0);
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    slv_b_ready_i  = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    slv_r_ready_i  = 1'b0;
    for (int i = 0; i < TableSize; i++) begin
      mdl_cnt[0][i] = 0;
      mdl_cnt[1][i] = 0;
    end
    base = slv_id_t'($urandom);
    for (int i = 0; i < 5; i++) begin
      ids[i] = base + slv_id_t'(i);
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // New input IDs fill the write table from the bottom, a repeat reuses its entry
    send_addr(1'b0, ids[0], $urandom, $urandom_range(3, 0));
    send_addr(1'b0, ids[1], $urandom, $urandom_range(3, 0));
    send_addr(1'b0, ids[0], $urandom, $urandom_range(3, 0));
    send_addr(1'b0, ids[2], $urandom, $urandom_range(3, 0));
    send_addr(1'b0, ids[3], $urandom, $urandom_range(3, 0));

    // Full table, then a B on entry 1 frees the slot the waiting request takes
    addr = $urandom;
    stall_addr(1'b0, ids[4], addr, 3);
    send_resp(1'b0, 1, 1'b1);
    send_addr(1'b0, ids[4], addr, $urandom_range(3, 0));

    // Entry 0 reaches its burst limit
    send_addr(1'b0, ids[0], $urandom, $urandom_range(3, 0));
    addr = $urandom;
    stall_addr(1'b0, ids[0], addr, 2);
    send_resp(1'b0, 0, 1'b1);
    send_addr(1'b0, ids[0], addr, $urandom_range(3, 0));

    // Reads start from an empty table while the write table is still busy
    send_addr(1'b1, ids[0], $urandom, $urandom_range(3, 0));
    send_addr(1'b1, ids[2], $urandom, $urandom_range(3, 0));
    send_resp(1'b1, 0, 1'b0);
    send_addr(1'b1, ids[1], $urandom, $urandom_range(3, 0));
    send_resp(1'b1, 0, 1'b1);
    send_addr(1'b1, ids[3], $urandom, $urandom_range(3, 0));

    for (int i = 0; i < TableSize; i++) begin
      while (mdl_cnt[0][i] != 0) begin
        send_resp(1'b0, i, 1'b1);
      end
      while (mdl_cnt[1][i] != 0) begin
        send_resp(1'b1, i, 1'b1);
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog.f
design/remap_cfg_pkg.sv
design/remap_types_pkg.sv
design/remap_table_if.sv
design/ax_issue.sv
design/id_remap_table.sv
design/resp_id_restore.sv
design/axi_id_remap_top.sv
verification/tb_axi_id_remap.sv
